/* common/cpu_pkg.sv */
// word, register index, instruction, control and pipeline stage types, opcodes and memory depths
package cpu_pkg;

   // default memory depths in words, log2
   localparam int IMEM_ADDR_W = 9;
   localparam int DMEM_ADDR_W = 10;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   typedef struct packed {
      logic [5:0] opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } instr_t;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_e;

   // operand source for the execute stage
   typedef enum logic [1:0] {
      FWD_REG = 2'd0,
      FWD_EX  = 2'd1,
      FWD_WB  = 2'd2
   } fwd_e;

   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_ADDI  = 6'h08;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;

   localparam logic [5:0] FN_ADD = 6'h20;
   localparam logic [5:0] FN_SUB = 6'h22;
   localparam logic [5:0] FN_AND = 6'h24;
   localparam logic [5:0] FN_OR  = 6'h25;
   localparam logic [5:0] FN_SLT = 6'h2a;

   typedef struct packed {
      logic     reg_write;
      reg_idx_t dest;
      logic     mem_read;
      logic     mem_write;
      logic     alu_src;
      alu_op_e  alu_op;
   } ctrl_t;

   typedef struct packed {
      ctrl_t    ctrl;
      reg_idx_t rs;
      reg_idx_t rt;
      word_t    a;
      word_t    b;
      word_t    imm;
   } id_ex_t;

   typedef struct packed {
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      reg_idx_t dest;
      word_t    result;
      word_t    store_data;
   } ex_mem_t;

   typedef struct packed {
      logic     reg_write;
      reg_idx_t dest;
      word_t    data;
   } wb_t;

endpackage

/* rtl/sram.sv */
// two-port synchronous word memory with a core port and an external port
`timescale 1ns/1ns

module sram #(
   parameter int ADDR_W = 9
) (
   input  logic           clk,
   input  cpu_pkg::word_t addr,
   input  logic           wen,
   input  logic           ren,
   input  cpu_pkg::word_t wdata,
   output cpu_pkg::word_t rdata,
   input  cpu_pkg::word_t addr_ext,
   input  logic           wen_ext,
   input  logic           ren_ext,
   input  cpu_pkg::word_t wdata_ext,
   output cpu_pkg::word_t rdata_ext
);

   cpu_pkg::word_t    mem [2**ADDR_W];
   logic [ADDR_W-1:0] core_idx;
   logic [ADDR_W-1:0] ext_idx;

   // core port is byte addressed, external port takes word indices
   assign core_idx = addr[ADDR_W+1:2];
   assign ext_idx  = addr_ext[ADDR_W-1:0];

   always_ff @(posedge clk) begin
      if (wen) begin
         mem[core_idx] <= wdata;
      end
      if (wen_ext) begin
         mem[ext_idx] <= wdata_ext;
      end
      // read data holds while ren is low
      if (ren) begin
         rdata <= mem[core_idx];
      end
      if (ren_ext) begin
         rdata_ext <= mem[ext_idx];
      end
   end

endmodule

/* core/fetch_stage.sv */
// program counter, instruction memory and the fetch output with its valid flag
`timescale 1ns/1ns

module fetch_stage #(
   parameter int ADDR_W = 9
) (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            enable,
   input  logic            stall,
   output cpu_pkg::instr_t instr,
   output logic            instr_valid,
   input  cpu_pkg::word_t  addr_ext,
   input  logic            wen_ext,
   input  logic            ren_ext,
   input  cpu_pkg::word_t  wdata_ext,
   output cpu_pkg::word_t  rdata_ext
);

   cpu_pkg::word_t pc;
   cpu_pkg::word_t imem_rdata;
   logic           fetch_en;

   // a stall keeps the pc and leaves the last read word on the output
   assign fetch_en = enable & ~stall;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc          <= '0;
         instr_valid <= 1'b0;
      end else if (fetch_en) begin
         pc          <= pc + 32'd4;
         instr_valid <= 1'b1;
      end
   end

   sram #(
      .ADDR_W(ADDR_W)
   ) imem (
      .clk      (clk),
      .addr     (pc),
      .wen      (1'b0),
      .ren      (fetch_en),
      .wdata    ('0),
      .rdata    (imem_rdata),
      .addr_ext (addr_ext),
      .wen_ext  (wen_ext),
      .ren_ext  (ren_ext),
      .wdata_ext(wdata_ext),
      .rdata_ext(rdata_ext)
   );

   assign instr = cpu_pkg::instr_t'(imem_rdata);

endmodule

/* core/decode_stage.sv */
// register file with write-through, immediate extension and the decode-to-execute register
`timescale 1ns/1ns

module decode_stage (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            enable,
   input  logic            stall,
   input  cpu_pkg::instr_t instr,
   input  logic            instr_valid,
   input  cpu_pkg::ctrl_t  ctrl,
   input  cpu_pkg::wb_t    wb,
   output cpu_pkg::id_ex_t id_ex
);

   // r0 is not stored
   cpu_pkg::word_t  regs [1:31];
   logic            wb_wr;
   logic [15:0]     imm16;
   cpu_pkg::word_t  rs_val;
   cpu_pkg::word_t  rt_val;
   cpu_pkg::id_ex_t id_ex_next;

   assign wb_wr = enable & wb.reg_write & (wb.dest != '0);

   always_ff @(posedge clk) begin
      if (wb_wr) begin
         regs[wb.dest] <= wb.data;
      end
   end

   // the write of this cycle is seen by the read
   function automatic cpu_pkg::word_t read_reg(cpu_pkg::reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end
      if (wb_wr && wb.dest == idx) begin
         return wb.data;
      end
      return regs[idx];
   endfunction

   always_comb begin
      rs_val = read_reg(instr.rs);
      rt_val = read_reg(instr.rt);
   end

   assign imm16 = {instr.rd, instr.shamt, instr.funct};

   always_comb begin
      id_ex_next      = '0;
      id_ex_next.ctrl = ctrl;
      id_ex_next.rs   = instr.rs;
      id_ex_next.rt   = instr.rt;
      id_ex_next.a    = rs_val;
      id_ex_next.b    = rt_val;
      id_ex_next.imm  = {{16{imm16[15]}}, imm16};
      // bubble on load-use stall or before the first fetch
      if (stall || !instr_valid) begin
         id_ex_next = '0;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ex <= '0;
      end else if (enable) begin
         id_ex <= id_ex_next;
      end
   end

endmodule

/* core/execute_stage.sv */
// forwarding operand muxes, the ALU and the execute-to-memory register
`timescale 1ns/1ns

module execute_stage (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             enable,
   input  cpu_pkg::id_ex_t  id_ex,
   input  cpu_pkg::fwd_e    fwd_a,
   input  cpu_pkg::fwd_e    fwd_b,
   input  cpu_pkg::word_t   ex_result,
   input  cpu_pkg::word_t   wb_data,
   output cpu_pkg::ex_mem_t ex_mem
);

   cpu_pkg::word_t op_a;
   cpu_pkg::word_t b_fwd;
   cpu_pkg::word_t op_b;
   cpu_pkg::word_t alu_out;

   function automatic cpu_pkg::word_t pick(cpu_pkg::fwd_e sel, cpu_pkg::word_t reg_val,
                                           cpu_pkg::word_t ex_val, cpu_pkg::word_t wb_val);
      case (sel)
         cpu_pkg::FWD_EX: return ex_val;
         cpu_pkg::FWD_WB: return wb_val;
         default:         return reg_val;
      endcase
   endfunction

   assign op_a  = pick(fwd_a, id_ex.a, ex_result, wb_data);
   // forwarded rt value is also the store data
   assign b_fwd = pick(fwd_b, id_ex.b, ex_result, wb_data);
   assign op_b  = id_ex.ctrl.alu_src ? id_ex.imm : b_fwd;

   always_comb begin
      case (id_ex.ctrl.alu_op)
         cpu_pkg::ALU_SUB: alu_out = op_a - op_b;
         cpu_pkg::ALU_AND: alu_out = op_a & op_b;
         cpu_pkg::ALU_OR:  alu_out = op_a | op_b;
         cpu_pkg::ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
         default:          alu_out = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem <= '0;
      end else if (enable) begin
         ex_mem.reg_write  <= id_ex.ctrl.reg_write;
         ex_mem.mem_read   <= id_ex.ctrl.mem_read;
         ex_mem.mem_write  <= id_ex.ctrl.mem_write;
         ex_mem.dest       <= id_ex.ctrl.dest;
         ex_mem.result     <= alu_out;
         ex_mem.store_data <= b_fwd;
      end
   end

endmodule

/* core/memory_stage.sv */
// data memory access, the memory-to-writeback register and the writeback select
`timescale 1ns/1ns

module memory_stage #(
   parameter int ADDR_W = 10
) (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             enable,
   input  cpu_pkg::ex_mem_t ex_mem,
   output cpu_pkg::wb_t     wb,
   input  cpu_pkg::word_t   addr_ext,
   input  logic             wen_ext,
   input  logic             ren_ext,
   input  cpu_pkg::word_t   wdata_ext,
   output cpu_pkg::word_t   rdata_ext
);

   logic              mw_reg_write;
   logic              mw_load;
   cpu_pkg::reg_idx_t mw_dest;
   cpu_pkg::word_t    mw_result;
   cpu_pkg::word_t    load_data;

   sram #(
      .ADDR_W(ADDR_W)
   ) dmem (
      .clk      (clk),
      .addr     (ex_mem.result),
      .wen      (enable & ex_mem.mem_write),
      .ren      (enable & ex_mem.mem_read),
      .wdata    (ex_mem.store_data),
      .rdata    (load_data),
      .addr_ext (addr_ext),
      .wen_ext  (wen_ext),
      .ren_ext  (ren_ext),
      .wdata_ext(wdata_ext),
      .rdata_ext(rdata_ext)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mw_reg_write <= 1'b0;
         mw_load      <= 1'b0;
         mw_dest      <= '0;
      end else if (enable) begin
         mw_reg_write <= ex_mem.reg_write;
         mw_load      <= ex_mem.mem_read;
         mw_dest      <= ex_mem.dest;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         mw_result <= ex_mem.result;
      end
   end

   // loaded word arrives from the memory in the same cycle as the registered result
   assign wb.reg_write = mw_reg_write;
   assign wb.dest      = mw_dest;
   assign wb.data      = mw_load ? load_data : mw_result;

endmodule

/* core/hazard_control.sv */
// opcode and function decode, forwarding selects and the load-use stall
`timescale 1ns/1ns

module hazard_control (
   input  cpu_pkg::instr_t  instr,
   input  logic             instr_valid,
   input  cpu_pkg::id_ex_t  id_ex,
   input  cpu_pkg::ex_mem_t ex_mem,
   input  cpu_pkg::wb_t     wb,
   output cpu_pkg::ctrl_t   ctrl,
   output logic             stall,
   output cpu_pkg::fwd_e    fwd_a,
   output cpu_pkg::fwd_e    fwd_b
);

   always_comb begin
      ctrl = '0;
      case (instr.opcode)
         cpu_pkg::OP_RTYPE: begin
            ctrl.reg_write = 1'b1;
            ctrl.dest      = instr.rd;
            case (instr.funct)
               cpu_pkg::FN_ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
               cpu_pkg::FN_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
               cpu_pkg::FN_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
               cpu_pkg::FN_OR:  ctrl.alu_op = cpu_pkg::ALU_OR;
               cpu_pkg::FN_SLT: ctrl.alu_op = cpu_pkg::ALU_SLT;
               // the all-zero no-op lands here
               default:         ctrl = '0;
            endcase
         end
         cpu_pkg::OP_ADDI: begin
            ctrl.reg_write = 1'b1;
            ctrl.dest      = instr.rt;
            ctrl.alu_src   = 1'b1;
         end
         cpu_pkg::OP_LW: begin
            ctrl.reg_write = 1'b1;
            ctrl.dest      = instr.rt;
            ctrl.mem_read  = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         cpu_pkg::OP_SW: begin
            ctrl.dest      = instr.rt;
            ctrl.mem_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         default: ctrl = '0;
      endcase
   end

   // a load in ex/mem has no data yet, so it never forwards from there
   function automatic cpu_pkg::fwd_e fwd_sel(cpu_pkg::reg_idx_t src, cpu_pkg::ex_mem_t em,
                                             cpu_pkg::wb_t w);
      if (em.reg_write && !em.mem_read && em.dest != '0 && em.dest == src) begin
         return cpu_pkg::FWD_EX;
      end
      if (w.reg_write && w.dest != '0 && w.dest == src) begin
         return cpu_pkg::FWD_WB;
      end
      return cpu_pkg::FWD_REG;
   endfunction

   assign fwd_a = fwd_sel(id_ex.rs, ex_mem, wb);
   assign fwd_b = fwd_sel(id_ex.rt, ex_mem, wb);

   // load in execute feeding the instruction in decode
   assign stall = instr_valid && id_ex.ctrl.mem_read && (id_ex.ctrl.dest != '0)
                  && (id_ex.ctrl.dest == instr.rs || id_ex.ctrl.dest == instr.rt);

endmodule

/* rtl/cpu.sv */
// cpu top level connecting the four stages and the hazard control
`timescale 1ns/1ns

module cpu #(
   parameter int IMEM_ADDR_W = cpu_pkg::IMEM_ADDR_W,
   parameter int DMEM_ADDR_W = cpu_pkg::DMEM_ADDR_W
) (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           enable,
   input  cpu_pkg::word_t addr_ext,
   input  logic           wen_ext,
   input  logic           ren_ext,
   input  cpu_pkg::word_t wdata_ext,
   output cpu_pkg::word_t rdata_ext,
   input  cpu_pkg::word_t addr_ext_2,
   input  logic           wen_ext_2,
   input  logic           ren_ext_2,
   input  cpu_pkg::word_t wdata_ext_2,
   output cpu_pkg::word_t rdata_ext_2
);

   cpu_pkg::instr_t  instr;
   logic             instr_valid;
   logic             stall;
   cpu_pkg::ctrl_t   ctrl;
   cpu_pkg::fwd_e    fwd_a;
   cpu_pkg::fwd_e    fwd_b;
   cpu_pkg::id_ex_t  id_ex;
   cpu_pkg::ex_mem_t ex_mem;
   cpu_pkg::wb_t     wb;

   hazard_control hazard_control_inst (
      .instr      (instr),
      .instr_valid(instr_valid),
      .id_ex      (id_ex),
      .ex_mem     (ex_mem),
      .wb         (wb),
      .ctrl       (ctrl),
      .stall      (stall),
      .fwd_a      (fwd_a),
      .fwd_b      (fwd_b)
   );

   fetch_stage #(
      .ADDR_W(IMEM_ADDR_W)
   ) fetch_stage_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .stall      (stall),
      .instr      (instr),
      .instr_valid(instr_valid),
      .addr_ext   (addr_ext),
      .wen_ext    (wen_ext),
      .ren_ext    (ren_ext),
      .wdata_ext  (wdata_ext),
      .rdata_ext  (rdata_ext)
   );

   decode_stage decode_stage_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .stall      (stall),
      .instr      (instr),
      .instr_valid(instr_valid),
      .ctrl       (ctrl),
      .wb         (wb),
      .id_ex      (id_ex)
   );

   execute_stage execute_stage_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .enable   (enable),
      .id_ex    (id_ex),
      .fwd_a    (fwd_a),
      .fwd_b    (fwd_b),
      .ex_result(ex_mem.result),
      .wb_data  (wb.data),
      .ex_mem   (ex_mem)
   );

   memory_stage #(
      .ADDR_W(DMEM_ADDR_W)
   ) memory_stage_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .enable   (enable),
      .ex_mem   (ex_mem),
      .wb       (wb),
      .addr_ext (addr_ext_2),
      .wen_ext  (wen_ext_2),
      .ren_ext  (ren_ext_2),
      .wdata_ext(wdata_ext_2),
      .rdata_ext(rdata_ext_2)
   );

endmodule

/* sim/cpu_assert.sv */
// concurrent assertions on the load-use stall, data memory writes and fetch start-up
`timescale 1ns/1ns

module cpu_assert (
   input logic           clk,
   input logic           arst_n,
   input logic           enable,
   input logic           stall,
   input logic           instr_valid,
   input logic           ext_wen,
   input cpu_pkg::word_t dmem_word
);

   int unsigned fail_count = 0;

   // a load-use hazard costs one bubble only
   stall_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      (enable && stall) |=> !stall)
      else begin
         fail_count++;
         $error("stall stayed high after an enabled cycle");
      end

   // word at the core data address keeps its value while the core is frozen
   frozen_no_store: assert property (@(posedge clk) disable iff (!arst_n)
      (!enable && !ext_wen) |=> (dmem_word === $past(dmem_word)))
      else begin
         fail_count++;
         $error("core data memory word changed while enable is low");
      end

   fetch_start: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(instr_valid) |-> $past(enable))
      else begin
         fail_count++;
         $error("instr_valid rose without an enabled cycle");
      end

endmodule

bind cpu cpu_assert cpu_assert_inst (
   .clk        (clk),
   .arst_n     (arst_n),
   .enable     (enable),
   .stall      (stall),
   .instr_valid(instr_valid),
   .ext_wen    (wen_ext_2),
   .dmem_word  (memory_stage_inst.dmem.mem[memory_stage_inst.dmem.core_idx])
);

/* sim/cpu_tb.sv */
// cpu testbench with clock, reset, test data reader, memory loader and compare tasks
`timescale 1ns/1ns

module cpu_tb;

   localparam int             WATCHDOG_CYCLES = 2000;
   // data word the program never touches, used while the core is frozen
   localparam int             SCRATCH_IDX     = 1000;
   localparam cpu_pkg::word_t SCRATCH_WORD    = 32'hc3a5_0000 + SCRATCH_IDX;

   logic           clk;
   logic           arst_n;
   logic           enable;
   cpu_pkg::word_t addr_ext;
   logic           wen_ext;
   logic           ren_ext;
   cpu_pkg::word_t wdata_ext;
   cpu_pkg::word_t rdata_ext;
   cpu_pkg::word_t addr_ext_2;
   logic           wen_ext_2;
   logic           ren_ext_2;
   cpu_pkg::word_t wdata_ext_2;
   cpu_pkg::word_t rdata_ext_2;

   cpu_pkg::word_t prog [$];
   int             exp_idx [$];
   cpu_pkg::word_t exp_word [$];
   int             run_len;
   int             freeze_at;

   cpu #(
      .IMEM_ADDR_W(cpu_pkg::IMEM_ADDR_W),
      .DMEM_ADDR_W(cpu_pkg::DMEM_ADDR_W)
   ) cpu_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .addr_ext   (addr_ext),
      .wen_ext    (wen_ext),
      .ren_ext    (ren_ext),
      .wdata_ext  (wdata_ext),
      .rdata_ext  (rdata_ext),
      .addr_ext_2 (addr_ext_2),
      .wen_ext_2  (wen_ext_2),
      .ren_ext_2  (ren_ext_2),
      .wdata_ext_2(wdata_ext_2),
      .rdata_ext_2(rdata_ext_2)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input cpu_pkg::word_t got,
                             input cpu_pkg::word_t exp);
      if (got !== exp) begin
         $display("Error: time %0t ns, %s = %h, expected %h", $time, name, got, exp);
         fail_stop("data word mismatch");
      end
   endtask

   task automatic check_instr(input string name, input cpu_pkg::instr_t got,
                              input cpu_pkg::instr_t exp);
      if (got !== exp) begin
         $display("Error: time %0t ns, %s = %h, expected %h", $time, name, got, exp);
         fail_stop("instruction word mismatch");
      end
   endtask

   // one tagged entry per line, lines starting with # are skipped
   task automatic read_testdata();
      int             fd;
      int             n;
      string          line;
      byte            tag;
      cpu_pkg::word_t v0;
      cpu_pkg::word_t v1;
      fd = $fopen("sim/cpu_testdata.txt", "r");
      if (fd == 0) begin
         fail_stop("cannot open sim/cpu_testdata.txt");
      end
      while ($fgets(line, fd) > 0) begin
         tag = line[0];
         n   = 0;
         case (tag)
            "i": begin
               n = $sscanf(line, "i %h", v0);
               prog.push_back(v0);
            end
            "r": n = $sscanf(line, "r %d %d", run_len, freeze_at);
            "m": begin
               n = $sscanf(line, "m %h %h", v0, v1);
               exp_idx.push_back(int'(v0));
               exp_word.push_back(v1);
            end
            default: n = -1;
         endcase
         if (n == 0) begin
            fail_stop("malformed line in the test data file");
         end
      end
      $fclose(fd);
      if (prog.size() == 0 || run_len <= freeze_at || exp_idx.size() == 0) begin
         fail_stop("test data file lacks a program, a run length or expected words");
      end
   endtask

   task automatic imem_write(input int idx, input cpu_pkg::word_t data);
      @(posedge clk);
      addr_ext  <= cpu_pkg::word_t'(idx);
      wdata_ext <= data;
      wen_ext   <= 1'b1;
      @(posedge clk);
      wen_ext <= 1'b0;
   endtask

   // read data is there after the edge that saw ren
   task automatic imem_read(input int idx, output cpu_pkg::word_t data);
      @(posedge clk);
      addr_ext <= cpu_pkg::word_t'(idx);
      ren_ext  <= 1'b1;
      @(posedge clk);
      ren_ext <= 1'b0;
      @(negedge clk);
      data = rdata_ext;
   endtask

   task automatic dmem_write(input int idx, input cpu_pkg::word_t data);
      @(posedge clk);
      addr_ext_2  <= cpu_pkg::word_t'(idx);
      wdata_ext_2 <= data;
      wen_ext_2   <= 1'b1;
      @(posedge clk);
      wen_ext_2 <= 1'b0;
   endtask

   task automatic dmem_read(input int idx, output cpu_pkg::word_t data);
      @(posedge clk);
      addr_ext_2 <= cpu_pkg::word_t'(idx);
      ren_ext_2  <= 1'b1;
      @(posedge clk);
      ren_ext_2 <= 1'b0;
      @(negedge clk);
      data = rdata_ext_2;
   endtask

   // exactly this many edges see enable high
   task automatic run_enabled(input int cycles);
      int i;
      @(posedge clk);
      enable <= 1'b1;
      for (i = 0; i < cycles; i++) begin
         @(posedge clk);
      end
      enable <= 1'b0;
   endtask

   initial begin
      cpu_pkg::word_t got;
      int             i;
      arst_n      = 1'b0;
      enable      = 1'b0;
      addr_ext    = '0;
      wen_ext     = 1'b0;
      ren_ext     = 1'b0;
      wdata_ext   = '0;
      addr_ext_2  = '0;
      wen_ext_2   = 1'b0;
      ren_ext_2   = 1'b0;
      wdata_ext_2 = '0;
      read_testdata();
      for (i = 0; i < 3; i++) begin
         @(posedge clk);
      end
      arst_n <= 1'b1;

      for (i = 0; i < prog.size(); i++) begin
         imem_write(i, prog[i]);
      end
      for (i = 0; i < prog.size(); i++) begin
         imem_read(i, got);
         check_instr("rdata_ext", cpu_pkg::instr_t'(got), cpu_pkg::instr_t'(prog[i]));
      end

      run_enabled(freeze_at);
      // core is frozen here, only the external port acts
      dmem_write(SCRATCH_IDX, SCRATCH_WORD);
      dmem_read(SCRATCH_IDX, got);
      check_word("rdata_ext_2", got, SCRATCH_WORD);
      run_enabled(run_len - freeze_at);

      for (i = 0; i < exp_idx.size(); i++) begin
         dmem_read(exp_idx[i], got);
         check_word("rdata_ext_2", got, exp_word[i]);
      end
      dmem_read(SCRATCH_IDX, got);
      check_word("rdata_ext_2", got, SCRATCH_WORD);

      if (cpu_inst.cpu_assert_inst.fail_count == 0) begin
         $display("test passed");
         $finish;
      end else begin
         fail_stop("a concurrent assertion on the core failed");
      end
   end

   initial begin
      int n;
      for (n = 0; n < WATCHDOG_CYCLES; n++) begin
         @(posedge clk);
      end
      fail_stop("timeout: the run did not finish within the cycle limit");
   end

endmodule

/* sim/cpu_testdata.txt */
# i <instruction word hex> | r <run cycles> <freeze after cycles>, decimal
# m <data word index hex> <expected data word hex>
i 20010ff0  # addi r1, r0, 0x0ff0
i 2002ff00  # addi r2, r0, -256
i 00221820  # add  r3, r1, r2
i ac030000  # sw   r3, 0(r0)
i 00412022  # sub  r4, r2, r1
i 00222824  # and  r5, r1, r2
i 00223025  # or   r6, r1, r2
i 0041382a  # slt  r7, r2, r1
i 0022402a  # slt  r8, r1, r2
i ac040004  # sw   r4, 4(r0)
i ac050008  # sw   r5, 8(r0)
i ac06000c  # sw   r6, 12(r0)
i ac070010  # sw   r7, 16(r0)
i ac080014  # sw   r8, 20(r0)
i 8c090000  # lw   r9, 0(r0)
i 212a0001  # addi r10, r9, 1
i ac0a0018  # sw   r10, 24(r0)
i 20200007  # addi r0, r1, 7
i ac00001c  # sw   r0, 28(r0)
i 00015820  # add  r11, r0, r1
i ac0b0020  # sw   r11, 32(r0)
i 00000000  # nop
r 32 10
m 000 00000ef0
m 001 ffffef10
m 002 00000f00
m 003 fffffff0
m 004 00000001
m 005 00000000
m 006 00000ef1
m 007 00000000
m 008 00000ff0

/* list.f */
common/cpu_pkg.sv
rtl/sram.sv
core/fetch_stage.sv
core/decode_stage.sv
core/execute_stage.sv
core/memory_stage.sv
core/hazard_control.sv
rtl/cpu.sv
sim/cpu_assert.sv
sim/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - common/cpu_pkg.sv
  - rtl/sram.sv
  - core/fetch_stage.sv
  - core/decode_stage.sv
  - core/execute_stage.sv
  - core/memory_stage.sv
  - core/hazard_control.sv
  - rtl/cpu.sv
  - target: simulation
    files:
      - sim/cpu_assert.sv
      - sim/cpu_tb.sv
